//--- hw/rcn_master.sv
`timescale 1ns/1ps

module rcn_master (
  input  logic               clk,
  input  logic               rst,
  input  rcn_pkg::rcn_flit_t ring_in,
  output rcn_pkg::rcn_flit_t ring_out,
  rcn_req_if.master_side     req,
  rcn_rsp_if.master_side     rsp
);
  import rcn_pkg::*;

  logic       my_rsp;
  logic       slot_free;
  logic       take;
  rcn_flit_t  flit_d;
  rcn_flit_t  flit_q;
  logic       vld_q;

  // A response addressed to this master is removed here, which frees its slot.
  assign my_rsp    = ring_in.vld && ring_in.rsp && (ring_in.id == MASTER_ID);
  assign slot_free = !ring_in.vld || my_rsp;
  assign take      = req.vld && slot_free;

  // Any flit that stays on the ring blocks insertion this cycle.
  assign req.busy = !slot_free;

  assign rsp.rdone = my_rsp && !ring_in.wr;
  assign rsp.wdone = my_rsp && ring_in.wr;
  assign rsp.seq   = ring_in.seq;
  assign rsp.mask  = ring_in.mask;
  assign rsp.addr  = {ring_in.waddr, 2'b00};
  assign rsp.data  = ring_in.data;

  always_comb begin
    if (take) begin
      flit_d.vld   = 1'b1;
      flit_d.rsp   = 1'b0;
      flit_d.wr    = req.wr;
      flit_d.id    = MASTER_ID;
      flit_d.seq   = req.seq;
      flit_d.mask  = req.mask;
      flit_d.waddr = req.waddr;
      flit_d.data  = req.wdata;
    end else if (slot_free) begin
      flit_d = '0;
    end else begin
      // Foreign traffic goes on unchanged.
      flit_d = ring_in;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      vld_q <= 1'b0;
    else
      vld_q <= flit_d.vld;
  end

  always_ff @(posedge clk) begin
    flit_q <= flit_d;
  end

  always_comb begin
    ring_out     = flit_q;
    ring_out.vld = vld_q;
  end

endmodule

//--- hw/rcn_master_buf.sv
`timescale 1ns/1ps

module rcn_master_buf (
  input  logic               clk,
  input  logic               rst,
  input  logic               cs,
  input  logic               wr,
  input  req_pkg::seq_t      seq,
  input  req_pkg::mask_t     mask,
  input  req_pkg::addr_t     addr,
  input  req_pkg::data_t     wdata,
  output logic               busy,
  output logic               issue,
  output req_pkg::seq_t      iss_seq,
  input  rcn_pkg::rcn_flit_t ring_in,
  output rcn_pkg::rcn_flit_t ring_out,
  output logic               rdone,
  output logic               wdone,
  output req_pkg::seq_t      rsp_seq,
  output req_pkg::mask_t     rsp_mask,
  output req_pkg::addr_t     rsp_addr,
  output req_pkg::data_t     rsp_data
);
  import req_pkg::*;

  buf_entry_t       entries [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] cnt;
  logic             push;
  logic             pop;
  buf_entry_t       head;

  rcn_req_if req_if ();
  rcn_rsp_if rsp_if ();

  assign busy = (cnt == CNT_W'(DEPTH));
  assign push = cs && !busy;
  assign pop  = req_if.vld && !req_if.busy;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      wptr <= '0;
      rptr <= '0;
    end else begin
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
      if (push)
        wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
      if (pop)
        rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      entries[wptr] <= '{seq: seq, wr: wr, mask: mask, waddr: addr[23:2], wdata: wdata};
  end

  // The head entry is offered to the ring master whenever the buffer is not empty.
  assign head         = entries[rptr];
  assign req_if.vld   = (cnt != '0);
  assign req_if.seq   = head.seq;
  assign req_if.wr    = head.wr;
  assign req_if.mask  = head.mask;
  assign req_if.waddr = head.waddr;
  assign req_if.wdata = head.wdata;

  assign issue   = pop;
  assign iss_seq = head.seq;

  rcn_master u_master (
    .clk      (clk),
    .rst      (rst),
    .ring_in  (ring_in),
    .ring_out (ring_out),
    .req      (req_if.master_side),
    .rsp      (rsp_if.master_side)
  );

  assign rdone    = rsp_if.rdone;
  assign wdone    = rsp_if.wdone;
  assign rsp_seq  = rsp_if.seq;
  assign rsp_mask = rsp_if.mask;
  assign rsp_addr = rsp_if.addr;
  assign rsp_data = rsp_if.data;

endmodule

//--- hw/rcn_pkg.sv
package rcn_pkg;

  // Word address width carried on the ring, for a 24-bit byte address.
  localparam int WADDR_W = 22;

  // Each slave memory holds 2**MEM_AW words.
  localparam int MEM_AW = 8;

  // The word-address bits above MEM_AW select the slave window.
  localparam int WIN_W = WADDR_W - MEM_AW;

  typedef logic [2:0] rcn_id_t;
  typedef logic [WIN_W-1:0] win_t;

  localparam rcn_id_t MASTER_ID = 3'd0;

  localparam win_t SLAVE0_BASE = win_t'(0);
  localparam win_t SLAVE1_BASE = win_t'(1);

  // One ring slot. A slave turns a request into a response in the same slot.
  typedef struct packed {
    logic               vld;
    logic               rsp;
    logic               wr;
    rcn_id_t            id;
    logic [4:0]         seq;
    logic [3:0]         mask;
    logic [WADDR_W-1:0] waddr;
    logic [31:0]        data;
  } rcn_flit_t;

endpackage

//--- hw/rcn_req_if.sv
`timescale 1ns/1ps

interface rcn_req_if;
  import req_pkg::*;

  logic   vld;
  seq_t   seq;
  logic   wr;
  mask_t  mask;
  waddr_t waddr;
  data_t  wdata;
  logic   busy;

  // A request moves in a cycle with vld high and busy low.
  modport buf_side (
    output vld, seq, wr, mask, waddr, wdata,
    input  busy
  );

  modport master_side (
    input  vld, seq, wr, mask, waddr, wdata,
    output busy
  );

endinterface

//--- hw/rcn_ring_top.sv
`timescale 1ns/1ps

module rcn_ring_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           cs,
  input  logic           wr,
  input  req_pkg::seq_t  seq,
  input  req_pkg::mask_t mask,
  input  req_pkg::addr_t addr,
  input  req_pkg::data_t wdata,
  output logic           busy,
  output logic           issue,
  output req_pkg::seq_t  iss_seq,
  output logic           rdone,
  output logic           wdone,
  output req_pkg::seq_t  rsp_seq,
  output req_pkg::mask_t rsp_mask,
  output req_pkg::addr_t rsp_addr,
  output req_pkg::data_t rsp_data
);
  import rcn_pkg::*;

  // Ring links in flow order, master to slave 0 to slave 1 and back.
  rcn_flit_t m_to_s0;
  rcn_flit_t s0_to_s1;
  rcn_flit_t s1_to_m;

  rcn_master_buf u_master_buf (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .wr       (wr),
    .seq      (seq),
    .mask     (mask),
    .addr     (addr),
    .wdata    (wdata),
    .busy     (busy),
    .issue    (issue),
    .iss_seq  (iss_seq),
    .ring_in  (s1_to_m),
    .ring_out (m_to_s0),
    .rdone    (rdone),
    .wdone    (wdone),
    .rsp_seq  (rsp_seq),
    .rsp_mask (rsp_mask),
    .rsp_addr (rsp_addr),
    .rsp_data (rsp_data)
  );

  rcn_slave_mem #(.BASE(SLAVE0_BASE)) u_slave0 (
    .clk      (clk),
    .rst      (rst),
    .ring_in  (m_to_s0),
    .ring_out (s0_to_s1)
  );

  rcn_slave_mem #(.BASE(SLAVE1_BASE)) u_slave1 (
    .clk      (clk),
    .rst      (rst),
    .ring_in  (s0_to_s1),
    .ring_out (s1_to_m)
  );

endmodule

//--- hw/rcn_rsp_if.sv
`timescale 1ns/1ps

interface rcn_rsp_if;
  import req_pkg::*;

  logic  rdone;
  logic  wdone;
  seq_t  seq;
  mask_t mask;
  addr_t addr;
  data_t data;

  // One cycle per response and no back-pressure.
  modport master_side (
    output rdone, wdone, seq, mask, addr, data
  );

  modport sink_side (
    input rdone, wdone, seq, mask, addr, data
  );

endinterface

//--- hw/rcn_slave_mem.sv
`timescale 1ns/1ps

module rcn_slave_mem #(
  parameter rcn_pkg::win_t BASE = rcn_pkg::SLAVE0_BASE
) (
  input  logic               clk,
  input  logic               rst,
  input  rcn_pkg::rcn_flit_t ring_in,
  output rcn_pkg::rcn_flit_t ring_out
);
  import rcn_pkg::*;

  logic [31:0]       mem [2**MEM_AW];
  logic              hit;
  logic [MEM_AW-1:0] idx;
  logic [31:0]       rd_word;
  rcn_flit_t         flit_d;
  rcn_flit_t         flit_q;
  logic              vld_q;

  // Only requests inside this window are answered. Responses always pass.
  assign hit = ring_in.vld && !ring_in.rsp && (ring_in.waddr[WADDR_W-1:MEM_AW] == BASE);
  assign idx = ring_in.waddr[MEM_AW-1:0];

  assign rd_word = mem[idx];

  always_ff @(posedge clk) begin
    if (hit && ring_in.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (ring_in.mask[i])
          mem[idx][8*i +: 8] <= ring_in.data[8*i +: 8];
      end
    end
  end

  // The response keeps id, seq, mask and waddr of the request.
  always_comb begin
    flit_d = ring_in;
    if (hit) begin
      flit_d.rsp = 1'b1;
      // A write echoes its own data, a read returns the whole stored word.
      if (!ring_in.wr)
        flit_d.data = rd_word;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      vld_q <= 1'b0;
    else
      vld_q <= flit_d.vld;
  end

  always_ff @(posedge clk) begin
    flit_q <= flit_d;
  end

  always_comb begin
    ring_out     = flit_q;
    ring_out.vld = vld_q;
  end

endmodule

//--- hw/req_pkg.sv
package req_pkg;

  typedef logic [4:0]  seq_t;
  typedef logic [3:0]  mask_t;
  typedef logic [23:0] addr_t;
  typedef logic [21:0] waddr_t;
  typedef logic [31:0] data_t;

  // Request buffer entries, at most 64.
  localparam int DEPTH = 32;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // The low two address bits are dropped when a request is queued.
  typedef struct packed {
    seq_t   seq;
    logic   wr;
    mask_t  mask;
    waddr_t waddr;
    data_t  wdata;
  } buf_entry_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output.
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing -Wno-fatal --top-module tb_rcn_ring -f vlog.f &&
./obj_dir/Vtb_rcn_ring | tee /dev/stderr | grep -F "Simulation finished: PASS" > /dev/null &&
echo "run_sim: simulation passed" ||
{
  echo "run_sim: simulation failed"
  exit 1
}

//--- test/tb_rcn_checks.svh
// Expected response, queued when the client request is accepted.
typedef struct packed {
  logic  wr;
  seq_t  seq;
  mask_t mask;
  addr_t addr;
  data_t data;
} exp_rsp_t;

exp_rsp_t exp_q [$];
seq_t     tag_q [$];

task automatic check_seq(input string name, input seq_t got, input seq_t want);
  if (got !== want)
    abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, want));
endtask

task automatic check_mask(input string name, input mask_t got, input mask_t want);
  if (got !== want)
    abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, want));
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t want);
  if (got !== want)
    abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, want));
endtask

task automatic check_data(input string name, input data_t got, input data_t want);
  if (got !== want)
    abort_run($sformatf("FAILED at %0t: %s is 0x%h, expected 0x%h", $time, name, got, want));
endtask

task automatic check_flag(input string name, input logic got, input logic want);
  if (got !== want)
    abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, want));
endtask

// Responses come back in issue order, so the oldest queued entry is the one expected.
task automatic check_response();
  exp_rsp_t want;
  if (rdone && wdone)
    abort_run("Both rdone and wdone are high in the same cycle.");
  if (exp_q.size() == 0)
    abort_run("A response arrived while no accepted request was outstanding.");
  if (done_n >= iss_n)
    abort_run("A response arrived for a request that was never issued.");
  want = exp_q.pop_front();
  if (want.wr && !wdone)
    abort_run("A write request was answered with rdone instead of wdone.");
  if (!want.wr && !rdone)
    abort_run("A read request was answered with wdone instead of rdone.");
  check_seq("rsp_seq", rsp_seq, want.seq);
  check_mask("rsp_mask", rsp_mask, want.mask);
  check_addr("rsp_addr", rsp_addr, want.addr);
  check_data("rsp_data", rsp_data, want.data);
  done_n++;
endtask

task automatic check_issue();
  if (tag_q.size() == 0)
    abort_run("issue pulsed while no accepted request was waiting.");
  check_seq("iss_seq", iss_seq, tag_q.pop_front());
  iss_n++;
endtask

//--- test/tb_rcn_ring.sv
`timescale 1ns/1ps

module tb_rcn_ring;
  import req_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int WORDS_PER_WIN = 16;
  localparam int N_WARM        = 2 * WORDS_PER_WIN;
  localparam int N_READ        = 32;
  localparam int N_MIX         = 200;
  localparam int N_BURST       = DEPTH + 16;
  localparam int N_TOTAL       = N_WARM + N_READ + N_MIX + N_BURST;

  logic  clk;
  logic  rst;
  logic  cs;
  logic  wr;
  seq_t  seq;
  mask_t mask;
  addr_t addr;
  data_t wdata;
  logic  busy;
  logic  issue;
  seq_t  iss_seq;
  logic  rdone;
  logic  wdone;
  seq_t  rsp_seq;
  mask_t rsp_mask;
  addr_t rsp_addr;
  data_t rsp_data;

  // Word model of both windows, indexed by byte address bits 10 to 2.
  data_t model_mem [512];
  seq_t  next_tag;
  int    sent_n;
  int    busy_rejects;
  int    acc_n;
  int    iss_n;
  int    done_n;

  rcn_ring_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .wr       (wr),
    .seq      (seq),
    .mask     (mask),
    .addr     (addr),
    .wdata    (wdata),
    .busy     (busy),
    .issue    (issue),
    .iss_seq  (iss_seq),
    .rdone    (rdone),
    .wdone    (wdone),
    .rsp_seq  (rsp_seq),
    .rsp_mask (rsp_mask),
    .rsp_addr (rsp_addr),
    .rsp_data (rsp_data)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  `include "tb_rcn_checks.svh"

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input mask_t m);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (m[b])
        res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // Window bit 10 picks the slave, the low two bits are random and must be dropped.
  function automatic addr_t pick_addr(input int win, input int idx);
    logic [1:0] low;
    low = 2'($urandom_range(3));
    return {13'd0, 1'(win), 8'(idx), low};
  endfunction

  task automatic record_request();
    exp_rsp_t want;
    int       w;
    w         = int'(addr[10:2]);
    want.wr   = wr;
    want.seq  = seq;
    want.mask = mask;
    want.addr = {addr[23:2], 2'b00};
    if (wr) begin
      want.data   = wdata;
      model_mem[w] = merge_bytes(model_mem[w], wdata, mask);
    end else begin
      want.data = model_mem[w];
    end
    exp_q.push_back(want);
    tag_q.push_back(seq);
    acc_n++;
  endtask

  // With hold set the request waits for busy low, otherwise it is driven regardless.
  task automatic send_req(input logic is_wr, input addr_t a, input mask_t m, input data_t d,
                          input bit hold);
    @(posedge clk);
    #2;
    while (hold && busy) begin
      cs = 1'b0;
      @(posedge clk);
      #2;
    end
    if (busy)
      busy_rejects++;
    cs       = 1'b1;
    wr       = is_wr;
    seq      = next_tag;
    mask     = m;
    addr     = a;
    wdata    = d;
    next_tag = next_tag + 1'b1;
    sent_n++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    cs = 1'b0;
  endtask

  task automatic wait_drain();
    idle_cycle();
    while (exp_q.size() != 0 || tag_q.size() != 0)
      @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (N_TOTAL * 400 + 2000) @(posedge clk);
    abort_run("Timeout: not every accepted request was answered in time.");
  end

  // Outputs are sampled mid-cycle, well away from the edge where inputs change.
  // The buffer holds every accepted request that has not been issued yet.
  always @(negedge clk) begin
    if (!rst) begin
      check_flag("busy", busy, (acc_n - iss_n) == DEPTH);
      if (rdone || wdone)
        check_response();
      if (issue)
        check_issue();
      if (cs && !busy)
        record_request();
    end
  end

  initial begin
    void'($urandom(59080));
    rst          = 1'b1;
    cs           = 1'b0;
    wr           = 1'b0;
    seq          = '0;
    mask         = '0;
    addr         = '0;
    wdata        = '0;
    next_tag     = '0;
    sent_n       = 0;
    busy_rejects = 0;
    acc_n        = 0;
    iss_n        = 0;
    done_n       = 0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    #10;
    if (busy || issue || rdone || wdone)
      abort_run("busy, issue, rdone or wdone is high right after reset.");

    for (int win = 0; win < 2; win++) begin
      for (int idx = 0; idx < WORDS_PER_WIN; idx++)
        send_req(1'b1, pick_addr(win, idx), 4'hf, $urandom(), 1'b1);
    end
    wait_drain();

    for (int i = 0; i < N_READ; i++)
      send_req(1'b0, pick_addr($urandom_range(1), $urandom_range(WORDS_PER_WIN - 1)),
               mask_t'($urandom_range(15)), $urandom(), 1'b1);
    wait_drain();

    for (int i = 0; i < N_MIX; i++) begin
      send_req(1'($urandom_range(1)),
               pick_addr($urandom_range(1), $urandom_range(WORDS_PER_WIN - 1)),
               mask_t'($urandom_range(15)), $urandom(), 1'b1);
      if ($urandom_range(3) == 0)
        idle_cycle();
    end

    // The ring frees one slot per cycle, so busy may stay low during the burst.
    for (int i = 0; i < N_BURST; i++)
      send_req(1'($urandom_range(1)),
               pick_addr($urandom_range(1), $urandom_range(WORDS_PER_WIN - 1)),
               mask_t'($urandom_range(15)), $urandom(), 1'b0);
    wait_drain();
    repeat (20) @(posedge clk);

    if (iss_n != acc_n || done_n != acc_n)
      abort_run($sformatf("Sent %0d, rejected %0d, accepted %0d, issued %0d, answered %0d.",
                          sent_n, busy_rejects, acc_n, iss_n, done_n));
    else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+test
hw/rcn_pkg.sv
hw/req_pkg.sv
hw/rcn_req_if.sv
hw/rcn_rsp_if.sv
hw/rcn_master.sv
hw/rcn_slave_mem.sv
hw/rcn_master_buf.sv
hw/rcn_ring_top.sv
test/tb_rcn_ring.sv
